// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the performance monitor testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_hpm_top \
    -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/sim_tb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== source/hpm_apb_access.sv ====
/*
 * apb3 slave for the performance monitor
 * write strobes to both banks, inhibit and overflow registers,
 * read data combine, slave error and the overflow interrupt
 */
`timescale 1ns/1ps
`default_nettype none

module hpm_apb_access (
    input  logic                              clk_i,
    input  logic                              rstn_i,
    // apb3 slave
    input  hpm_pkg::apb_addr_t                paddr_i,
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  hpm_pkg::word_t                    pwdata_i,
    output hpm_pkg::word_t                    prdata_o,
    output logic                              pready_o,
    output logic                              pslverr_o,
    // counter banks
    hpm_bus_if.access                         fixed_bus,
    hpm_bus_if.access                         event_bus,
    input  logic [hpm_pkg::HPM_OVF_WIDTH-1:0] ovf_set_i,  // wrap pulses
    output logic                              irq_o
);

    logic access;  // access cycle, always completes
    logic wr;      // write in the access cycle

    hpm_pkg::word_t                    inhibit_q;
    logic [hpm_pkg::HPM_OVF_WIDTH-1:0] status_q;  // sticky wrap flags
    logic [hpm_pkg::HPM_OVF_WIDTH-1:0] enable_q;  // irq mask
    logic [hpm_pkg::HPM_OVF_WIDTH-1:0] clr;

    logic           own_hit;
    hpm_pkg::word_t own_rdata;

    assign access   = psel_i && penable_i;
    assign wr       = access && pwrite_i;
    assign pready_o = 1'b1;  // no wait states

    // ------------------------------------------------
    // bank links, same view for both
    // ------------------------------------------------
    assign fixed_bus.addr    = paddr_i;
    assign fixed_bus.wr_en   = wr;
    assign fixed_bus.wdata   = pwdata_i;
    assign fixed_bus.inhibit = inhibit_q;
    assign event_bus.addr    = paddr_i;
    assign event_bus.wr_en   = wr;
    assign event_bus.wdata   = pwdata_i;
    assign event_bus.inhibit = inhibit_q;

    // local registers
    assign clr = (wr && paddr_i == hpm_pkg::ADDR_OVF_STATUS) ?
                 pwdata_i[hpm_pkg::HPM_OVF_WIDTH-1:0] : '0;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            inhibit_q <= '0;
            enable_q  <= '0;
            status_q  <= '0;
            irq_o     <= 1'b0;
        end else begin
            if (wr && paddr_i == hpm_pkg::ADDR_INHIBIT) begin
                inhibit_q <= pwdata_i;  // banks see it from the next edge
            end
            if (wr && paddr_i == hpm_pkg::ADDR_OVF_ENABLE) begin
                enable_q <= pwdata_i[hpm_pkg::HPM_OVF_WIDTH-1:0];
            end
            status_q <= (status_q & ~clr) | ovf_set_i;  // a new wrap wins a clear
            irq_o    <= |(status_q & enable_q);         // one cycle behind status
        end
    end

    // ------------------------------------------------
    // read side
    // ------------------------------------------------
    always_comb begin
        own_hit   = 1'b1;
        own_rdata = '0;
        case (paddr_i)
            hpm_pkg::ADDR_INHIBIT:    own_rdata = inhibit_q;
            hpm_pkg::ADDR_OVF_STATUS: own_rdata = hpm_pkg::word_t'(status_q);
            hpm_pkg::ADDR_OVF_ENABLE: own_rdata = hpm_pkg::word_t'(enable_q);
            default:                  own_hit   = 1'b0;
        endcase
    end

    // banks decode for themselves, hits never overlap
    assign prdata_o  = own_hit       ? own_rdata       :
                       fixed_bus.hit ? fixed_bus.rdata :
                       event_bus.hit ? event_bus.rdata : '0;
    assign pslverr_o = access && !(own_hit || fixed_bus.hit || event_bus.hit);

    // access phase only right after a setup phase
    a_setup_first: assert property (@(posedge clk_i) disable iff (!rstn_i)
        penable_i |-> $past(psel_i && !penable_i));

endmodule

`default_nettype wire

// ==== source/hpm_bus_if.sv ====
/*
 * register access link between the apb unit and one counter bank
 * access side drives address, write strobe, data and inhibit word
 */
`timescale 1ns/1ps
`default_nettype none

interface hpm_bus_if;

    hpm_pkg::apb_addr_t addr;     // apb byte address, passed straight through
    logic               wr_en;    // one cycle, access cycle of a write
    hpm_pkg::word_t     wdata;    // write data word
    hpm_pkg::word_t     inhibit;  // current inhibit register
    hpm_pkg::word_t     rdata;    // bank read data, zero when not hit
    logic               hit;      // bank owns addr

    // apb side
    modport access (
        output addr, wr_en, wdata, inhibit,
        input  rdata, hit
    );

    // counter bank side
    modport bank (
        input  addr, wr_en, wdata, inhibit,
        output rdata, hit
    );

endinterface

`default_nettype wire

// ==== source/hpm_event_counters.sv ====
/*
 * programmable event counter bank
 * per slot selector, 64 bit counter, inhibit and wrap detection
 */
`timescale 1ns/1ps
`default_nettype none

module hpm_event_counters #(
    parameter int NUM_COUNTERS = hpm_pkg::HPM_NUM_COUNTERS
) (
    input  logic                               clk_i,
    input  logic                               rstn_i,
    input  logic [hpm_pkg::HPM_NUM_EVENTS-1:0] event_i,
    hpm_bus_if.bank                            bus_i,
    output logic [NUM_COUNTERS-1:0]            ovf_set_o  // one cycle per wrap
);

    hpm_pkg::count_t cnt_q [NUM_COUNTERS];
    hpm_pkg::evsel_t sel_q [NUM_COUNTERS];

    logic [NUM_COUNTERS-1:0] lo_hit;   // counter low word addressed
    logic [NUM_COUNTERS-1:0] hi_hit;   // counter high word addressed
    logic [NUM_COUNTERS-1:0] sel_hit;  // selector addressed
    logic [NUM_COUNTERS-1:0] inc;      // selected event seen, not inhibited
    logic [NUM_COUNTERS-1:0] ovf_q;

    // code space view of the events, code e picks bit e
    // code 0 and codes above the event count read as zero
    logic [hpm_pkg::EVSEL_CODES-1:0] ev_ext;

    assign ev_ext = {{(hpm_pkg::EVSEL_CODES - hpm_pkg::HPM_NUM_EVENTS - 1){1'b0}},
                     event_i, 1'b0};

    // ------------------------------------------------
    // one slot per counter
    // ------------------------------------------------
    for (genvar k = 0; k < NUM_COUNTERS; k++) begin : g_slot

        assign lo_hit[k]  = bus_i.addr == hpm_pkg::apb_addr_t'(hpm_pkg::ADDR_HPM_BASE + 8 * k);
        assign hi_hit[k]  = bus_i.addr ==
                            hpm_pkg::apb_addr_t'(hpm_pkg::ADDR_HPM_BASE + 8 * k + 4);
        assign sel_hit[k] = bus_i.addr ==
                            hpm_pkg::apb_addr_t'(hpm_pkg::ADDR_EVSEL_BASE + 4 * k);

        assign inc[k] = ev_ext[sel_q[k]] && !bus_i.inhibit[hpm_pkg::INH_HPM_BASE + k];

        // event selector
        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                sel_q[k] <= '0;  // no event
            end else if (bus_i.wr_en && sel_hit[k]) begin
                sel_q[k] <= bus_i.wdata[hpm_pkg::EVSEL_WIDTH-1:0];
            end
        end

        // counter, word preset beats the increment
        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                cnt_q[k] <= '0;
            end else if (bus_i.wr_en && lo_hit[k]) begin
                cnt_q[k][31:0] <= bus_i.wdata;
            end else if (bus_i.wr_en && hi_hit[k]) begin
                cnt_q[k][63:32] <= bus_i.wdata;
            end else if (inc[k]) begin
                cnt_q[k] <= cnt_q[k] + 1'b1;
            end
        end

        // wrap flag, high in the cycle after the all ones to zero edge
        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                ovf_q[k] <= 1'b0;
            end else begin
                ovf_q[k] <= inc[k] && (&cnt_q[k]) &&
                            !(bus_i.wr_en && (lo_hit[k] || hi_hit[k]));
            end
        end

        // a raised flag always sits on a counter that just wrapped to zero
        a_ovf_zero: assert property (@(posedge clk_i) disable iff (!rstn_i)
            ovf_q[k] |-> cnt_q[k] == '0);
    end

    assign ovf_set_o = ovf_q;

    // ------------------------------------------------
    // read mux
    // ------------------------------------------------
    always_comb begin
        bus_i.rdata = '0;
        for (int k = 0; k < NUM_COUNTERS; k++) begin
            if (lo_hit[k]) begin
                bus_i.rdata = cnt_q[k][31:0];
            end
            if (hi_hit[k]) begin
                bus_i.rdata = cnt_q[k][63:32];
            end
            if (sel_hit[k]) begin
                bus_i.rdata = hpm_pkg::word_t'(sel_q[k]);  // zero extended code
            end
        end
    end

    assign bus_i.hit = |{lo_hit, hi_hit, sel_hit};

endmodule

`default_nettype wire

// ==== source/hpm_fixed_counters.sv ====
/*
 * fixed counters: free running cycle and retired instructions
 * word preset over the bank link, per counter inhibit
 */
`timescale 1ns/1ps
`default_nettype none

module hpm_fixed_counters (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        retire_i,  // one instruction retired this cycle
    hpm_bus_if.bank     bus_i
);

    hpm_pkg::count_t cycle_q;
    hpm_pkg::count_t instret_q;

    logic hit_cyc_lo, hit_cyc_hi, hit_ins_lo, hit_ins_hi;
    logic cyc_wr, ins_wr;  // any word write to that counter

    assign hit_cyc_lo = bus_i.addr == hpm_pkg::ADDR_CYCLE_LO;
    assign hit_cyc_hi = bus_i.addr == hpm_pkg::ADDR_CYCLE_HI;
    assign hit_ins_lo = bus_i.addr == hpm_pkg::ADDR_INSTRET_LO;
    assign hit_ins_hi = bus_i.addr == hpm_pkg::ADDR_INSTRET_HI;
    assign cyc_wr     = bus_i.wr_en && (hit_cyc_lo || hit_cyc_hi);
    assign ins_wr     = bus_i.wr_en && (hit_ins_lo || hit_ins_hi);

    // cycle counter, a preset word wins over the increment
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cycle_q <= '0;
        end else if (bus_i.wr_en && hit_cyc_lo) begin
            cycle_q[31:0] <= bus_i.wdata;
        end else if (bus_i.wr_en && hit_cyc_hi) begin
            cycle_q[63:32] <= bus_i.wdata;
        end else if (!bus_i.inhibit[hpm_pkg::INH_CYCLE_BIT]) begin
            cycle_q <= cycle_q + 1'b1;  // every clock
        end
    end

    // retired instruction counter
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            instret_q <= '0;
        end else if (bus_i.wr_en && hit_ins_lo) begin
            instret_q[31:0] <= bus_i.wdata;
        end else if (bus_i.wr_en && hit_ins_hi) begin
            instret_q[63:32] <= bus_i.wdata;
        end else if (retire_i && !bus_i.inhibit[hpm_pkg::INH_INSTRET_BIT]) begin
            instret_q <= instret_q + 1'b1;
        end
    end

    // read side, combinational
    assign bus_i.hit   = hit_cyc_lo || hit_cyc_hi || hit_ins_lo || hit_ins_hi;
    assign bus_i.rdata = hit_cyc_lo ? cycle_q[31:0]    :
                         hit_cyc_hi ? cycle_q[63:32]   :
                         hit_ins_lo ? instret_q[31:0]  :
                         hit_ins_hi ? instret_q[63:32] : '0;

    // inhibit held from the apb unit freezes the count at the next edge
    a_cycle_frozen: assert property (@(posedge clk_i) disable iff (!rstn_i)
        bus_i.inhibit[hpm_pkg::INH_CYCLE_BIT] && !cyc_wr |=> $stable(cycle_q));
    a_instret_frozen: assert property (@(posedge clk_i) disable iff (!rstn_i)
        bus_i.inhibit[hpm_pkg::INH_INSTRET_BIT] && !ins_wr |=> $stable(instret_q));

endmodule

`default_nettype wire

// ==== source/hpm_pkg.sv ====
/*
 * performance monitor shared definitions
 * bus and counter widths, event selector codes, inhibit bit layout,
 * counter count and the register address map
 */
`default_nettype none

package hpm_pkg;

    // ------------------------------------------------
    // widths and sizes
    // ------------------------------------------------
    localparam int ADDR_WIDTH       = 12;                  // apb byte address
    localparam int WORD_WIDTH       = 32;                  // apb data word
    localparam int COUNT_WIDTH      = 64;                  // every counter
    localparam int EVSEL_WIDTH      = 5;                   // selector code
    localparam int EVSEL_CODES      = 2**EVSEL_WIDTH;      // codes 0..31
    localparam int HPM_NUM_EVENTS   = 16;                  // event_i lines
    localparam int HPM_NUM_COUNTERS = 4;                   // programmable slots
    localparam int HPM_OVF_WIDTH    = HPM_NUM_COUNTERS;    // one flag per slot

    typedef logic [ADDR_WIDTH-1:0]  apb_addr_t;
    typedef logic [WORD_WIDTH-1:0]  word_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;
    typedef logic [EVSEL_WIDTH-1:0] evsel_t;  // 0 = none, e selects event_i[e-1]

    // inhibit register bits, bit 1 is left free
    localparam int INH_CYCLE_BIT   = 0;
    localparam int INH_INSTRET_BIT = 2;
    localparam int INH_HPM_BASE    = 3;  // bit 3+k freezes event counter k

    // ------------------------------------------------
    // address map, byte addresses
    // ------------------------------------------------
    localparam apb_addr_t ADDR_CYCLE_LO   = 12'h000;
    localparam apb_addr_t ADDR_CYCLE_HI   = 12'h004;
    localparam apb_addr_t ADDR_INSTRET_LO = 12'h008;
    localparam apb_addr_t ADDR_INSTRET_HI = 12'h00C;
    localparam apb_addr_t ADDR_INHIBIT    = 12'h010;
    localparam apb_addr_t ADDR_OVF_STATUS = 12'h014;  // write 1 to clear
    localparam apb_addr_t ADDR_OVF_ENABLE = 12'h018;
    localparam apb_addr_t ADDR_HPM_BASE   = 12'h100;  // lo at +8k, hi at +8k+4
    localparam apb_addr_t ADDR_EVSEL_BASE = 12'h200;  // selector k at +4k

endpackage

`default_nettype wire

// ==== source/hpm_top.sv ====
/*
 * performance monitor top level
 * apb unit, fixed counters and event bank on two bank links
 */
`timescale 1ns/1ps
`default_nettype none

module hpm_top (
    input  logic                               clk_i,
    input  logic                               rstn_i,
    // apb3 slave
    input  hpm_pkg::apb_addr_t                 paddr_i,
    input  logic                               psel_i,
    input  logic                               penable_i,
    input  logic                               pwrite_i,
    input  hpm_pkg::word_t                     pwdata_i,
    output hpm_pkg::word_t                     prdata_o,
    output logic                               pready_o,
    output logic                               pslverr_o,
    // events
    input  logic [hpm_pkg::HPM_NUM_EVENTS-1:0] event_i,
    input  logic                               retire_i,
    // overflow interrupt
    output logic                               irq_o
);

    logic [hpm_pkg::HPM_OVF_WIDTH-1:0] ovf_set;  // event bank wrap pulses

    hpm_bus_if fixed_bus ();
    hpm_bus_if event_bus ();

    hpm_apb_access u_access (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .paddr_i   (paddr_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .fixed_bus (fixed_bus),
        .event_bus (event_bus),
        .ovf_set_i (ovf_set),
        .irq_o     (irq_o)
    );

    hpm_fixed_counters u_fixed (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .retire_i (retire_i),
        .bus_i    (fixed_bus)
    );

    hpm_event_counters #(
        .NUM_COUNTERS (hpm_pkg::HPM_NUM_COUNTERS)
    ) u_events (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .event_i   (event_i),
        .bus_i     (event_bus),
        .ovf_set_o (ovf_set)
    );

endmodule

`default_nettype wire

// ==== verification/tb_hpm_top.sv ====
/*
 * testbench for the performance monitor top level
 * clock, reset, lfsr event stimulus, apb tasks, reference model and checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_hpm_top;

    localparam int TIMEOUT = 200;                        // cycles allowed per wait
    localparam int NC      = hpm_pkg::HPM_NUM_COUNTERS;
    localparam hpm_pkg::evsel_t SEL_CODE [NC] = '{5'd1, 5'd6, 5'd16, 5'd20};  // 20 is out of range

    logic                               clk_i;
    logic                               rstn_i    = 1'b0;
    hpm_pkg::apb_addr_t                 paddr_i   = '0;
    logic                               psel_i    = 1'b0;
    logic                               penable_i = 1'b0;
    logic                               pwrite_i  = 1'b0;
    hpm_pkg::word_t                     pwdata_i  = '0;
    hpm_pkg::word_t                     prdata_o;
    logic                               pready_o;
    logic                               pslverr_o;
    logic [hpm_pkg::HPM_NUM_EVENTS-1:0] event_i   = '0;
    logic                               retire_i  = 1'b0;
    logic                               irq_o;

    int              errors     = 0;
    logic [31:0]     total_clks = '0;       // every edge since time zero
    logic [15:0]     lfsr       = 16'd10217;
    logic            stim_en    = 1'b0;     // random events on
    logic [15:0]     forced_ev  = '0;       // events while random stimulus is off
    hpm_pkg::count_t model_cnt [NC] = '{default: '0};
    hpm_pkg::evsel_t model_sel [NC] = '{default: '0};
    hpm_pkg::count_t model_instret  = '0;
    hpm_pkg::word_t  model_inh      = '0;

    hpm_top dut (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .paddr_i   (paddr_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .event_i   (event_i),
        .retire_i  (retire_i),
        .irq_o     (irq_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;  // 40 ns period
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    // x^16 + x^14 + x^13 + x^11 + 1, new bit enters at bit 0
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic event_selected(input hpm_pkg::evsel_t code, input logic [15:0] ev);
        if (code == 5'd0 || code > 5'd16) return 1'b0;  // no event or unused code
        return ev[4'(code - 5'd1)];
    endfunction

    function automatic hpm_pkg::apb_addr_t cnt_addr(input int k);
        return hpm_pkg::apb_addr_t'(hpm_pkg::ADDR_HPM_BASE + 8 * k);  // low word
    endfunction

    function automatic hpm_pkg::apb_addr_t sel_addr(input int k);
        return hpm_pkg::apb_addr_t'(hpm_pkg::ADDR_EVSEL_BASE + 4 * k);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $finish;
    endtask

    task automatic check_word(input string name, input hpm_pkg::word_t got,
                              input hpm_pkg::word_t exp);
        assert (got === exp) else begin
            errors++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    // stays in the access cycle until pready_o, sampling at the falling edge
    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk_i);
        while (pready_o !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (pready_o !== 1'b1) abort_run("apb transfer never completed, pready_o stayed low");
    endtask

    task automatic apb_access(input hpm_pkg::apb_addr_t addr, input logic write,
                              input hpm_pkg::word_t data, output hpm_pkg::word_t rdata,
                              output logic err);
        @(posedge clk_i);
        paddr_i   <= addr;  // setup cycle
        pwrite_i  <= write;
        pwdata_i  <= data;
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        @(posedge clk_i);
        penable_i <= 1'b1;  // access cycle
        wait_ready();
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk_i);  // write lands on this edge
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic apb_write(input hpm_pkg::apb_addr_t addr, input hpm_pkg::word_t data);
        hpm_pkg::word_t d;
        logic           e;
        apb_access(addr, 1'b1, data, d, e);
    endtask

    task automatic apb_read(input hpm_pkg::apb_addr_t addr, output hpm_pkg::word_t d,
                            output logic e);
        apb_access(addr, 1'b0, '0, d, e);
    endtask

    task automatic check_read(input hpm_pkg::apb_addr_t addr, input hpm_pkg::word_t exp);
        hpm_pkg::word_t d;
        logic           e;
        apb_read(addr, d, e);
        check_word($sformatf("prdata_o at %h", addr), d, exp);
        check_word($sformatf("pslverr_o at %h", addr), {31'b0, e}, '0);
    endtask

    task automatic check_counter(input hpm_pkg::apb_addr_t lo, input hpm_pkg::count_t exp);
        check_read(lo, exp[31:0]);
        check_read(lo + 12'h004, exp[63:32]);
    endtask

    task automatic wait_irq(input logic level);
        int n;
        n = 0;
        @(negedge clk_i);
        while (irq_o !== level && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (irq_o !== level) abort_run("irq_o never reached the expected level");
    endtask

    // --------------------------------------------------
    // stimulus and reference model
    // --------------------------------------------------
    always @(posedge clk_i) begin : stim_drive
        logic [15:0] ev;
        logic [15:0] s;
        total_clks <= total_clks + 32'd1;
        if (stim_en) begin
            s = lfsr;
            for (int i = 0; i < 16; i++) begin
                s     = lfsr_step(s);  // one step per bit taken
                ev[i] = s[0];
            end
            s = lfsr_step(s);
            lfsr     <= s;
            event_i  <= ev;
            retire_i <= s[0];
        end else begin
            event_i  <= forced_ev;
            retire_i <= 1'b0;
        end
    end

    // counts on the edge that samples an input, word writes win, inhibit lags one edge
    always @(posedge clk_i) begin : ref_model
        logic           wr_now;
        hpm_pkg::word_t inh_sh;
        wr_now = rstn_i && psel_i && penable_i && pwrite_i;
        for (int k = 0; k < NC; k++) begin
            inh_sh = model_inh >> (hpm_pkg::INH_HPM_BASE + k);
            if (wr_now && paddr_i == cnt_addr(k)) begin
                model_cnt[k][31:0] = pwdata_i;
            end else if (wr_now && paddr_i == cnt_addr(k) + 12'h004) begin
                model_cnt[k][63:32] = pwdata_i;
            end else if (rstn_i && !inh_sh[0] && event_selected(model_sel[k], event_i)) begin
                model_cnt[k] = model_cnt[k] + 64'd1;
            end
            if (wr_now && paddr_i == sel_addr(k)) begin
                model_sel[k] = pwdata_i[hpm_pkg::EVSEL_WIDTH-1:0];
            end
        end
        if (wr_now && paddr_i == hpm_pkg::ADDR_INSTRET_LO) begin
            model_instret[31:0] = pwdata_i;
        end else if (wr_now && paddr_i == hpm_pkg::ADDR_INSTRET_HI) begin
            model_instret[63:32] = pwdata_i;
        end else if (rstn_i && retire_i && !model_inh[hpm_pkg::INH_INSTRET_BIT]) begin
            model_instret = model_instret + 64'd1;
        end
        if (wr_now && paddr_i == hpm_pkg::ADDR_INHIBIT) begin
            model_inh = pwdata_i;  // after this edge's counting
        end
    end

    // protocol checks on the slave side
    a_pready_high: assert property (@(posedge clk_i) disable iff (!rstn_i) pready_o)
        else begin
            errors++;
            $display("pready_o went low although the slave has no wait states");
        end
    a_slverr_access: assert property (@(posedge clk_i) disable iff (!rstn_i)
        pslverr_o |-> psel_i && penable_i)
        else begin
            errors++;
            $display("pslverr_o was raised outside an access cycle");
        end

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin : main
        hpm_pkg::word_t d;
        hpm_pkg::word_t c0;
        logic           e;
        int             n;
        repeat (5) @(posedge clk_i);
        rstn_i <= 1'b1;

        // reset values, cycle is the only one running
        check_read(hpm_pkg::ADDR_CYCLE_HI, '0);
        check_read(hpm_pkg::ADDR_INSTRET_LO, '0);
        check_read(hpm_pkg::ADDR_INSTRET_HI, '0);
        check_read(hpm_pkg::ADDR_INHIBIT, '0);
        check_read(hpm_pkg::ADDR_OVF_STATUS, '0);
        check_read(hpm_pkg::ADDR_OVF_ENABLE, '0);
        for (int k = 0; k < NC; k++) begin
            check_counter(cnt_addr(k), '0);
            check_read(sel_addr(k), '0);
        end
        apb_read(hpm_pkg::ADDR_CYCLE_LO, d, e);
        assert (d != '0 && d < total_clks) else begin
            errors++;
            $display("Fail prdata_o cycle lo got %h expected nonzero below %h", d, total_clks);
        end
        check_word("irq_o", {31'b0, irq_o}, '0);

        // read back, everything frozen first
        apb_write(hpm_pkg::ADDR_INHIBIT, '1);
        check_read(hpm_pkg::ADDR_INHIBIT, '1);
        apb_write(hpm_pkg::ADDR_OVF_ENABLE, 32'hF);
        check_read(hpm_pkg::ADDR_OVF_ENABLE, 32'hF);
        apb_write(hpm_pkg::ADDR_OVF_ENABLE, '0);
        for (int k = 0; k < NC; k++) begin
            apb_write(cnt_addr(k), 32'hA5A5_0000 + k);
            apb_write(cnt_addr(k) + 12'h004, 32'h5A5A_0000 + k);
            check_counter(cnt_addr(k), {32'h5A5A_0000 + k, 32'hA5A5_0000 + k});
            apb_write(sel_addr(k), {27'b0, SEL_CODE[k]});
            check_read(sel_addr(k), {27'b0, SEL_CODE[k]});
        end
        apb_write(hpm_pkg::ADDR_CYCLE_LO, 32'h1234_5678);
        apb_write(hpm_pkg::ADDR_CYCLE_HI, 32'h0000_00C3);
        check_counter(hpm_pkg::ADDR_CYCLE_LO, 64'h0000_00C3_1234_5678);
        apb_write(hpm_pkg::ADDR_INSTRET_LO, 32'hDEAD_BEEF);
        apb_write(hpm_pkg::ADDR_INSTRET_HI, 32'h0000_0017);
        check_counter(hpm_pkg::ADDR_INSTRET_LO, 64'h0000_0017_DEAD_BEEF);
        apb_read(12'h01C, d, e);  // hole in the map
        check_word("pslverr_o at 01c", {31'b0, e}, 32'h1);
        check_word("prdata_o at 01c", d, '0);

        // counting stretch between two inhibit writes
        for (int k = 0; k < NC; k++) begin
            apb_write(cnt_addr(k), '0);
            apb_write(cnt_addr(k) + 12'h004, '0);
        end
        apb_write(hpm_pkg::ADDR_INSTRET_LO, '0);
        apb_write(hpm_pkg::ADDR_INSTRET_HI, '0);
        @(posedge clk_i);
        stim_en <= 1'b1;
        apb_write(hpm_pkg::ADDR_INHIBIT, '0);
        repeat (120) @(posedge clk_i);
        apb_write(hpm_pkg::ADDR_INHIBIT, '1);
        @(negedge clk_i);  // model settles on the last counting edge
        for (int k = 0; k < NC; k++) check_counter(cnt_addr(k), model_cnt[k]);
        check_counter(hpm_pkg::ADDR_INSTRET_LO, model_instret);

        // frozen while random events keep coming
        apb_read(hpm_pkg::ADDR_CYCLE_LO, c0, e);
        repeat (50) @(posedge clk_i);
        for (int k = 0; k < NC; k++) check_counter(cnt_addr(k), model_cnt[k]);
        check_counter(hpm_pkg::ADDR_INSTRET_LO, model_instret);
        apb_read(hpm_pkg::ADDR_CYCLE_LO, d, e);
        check_word("prdata_o cycle lo", d, c0);

        // wrap of counter 1 on two forced events
        @(posedge clk_i);
        stim_en <= 1'b0;
        apb_write(cnt_addr(1) + 12'h004, '1);
        apb_write(cnt_addr(1), 32'hFFFF_FFFE);
        apb_write(hpm_pkg::ADDR_INHIBIT, ~(32'h1 << (hpm_pkg::INH_HPM_BASE + 1)));
        @(posedge clk_i);
        forced_ev <= 16'h1 << (SEL_CODE[1] - 5'd1);
        repeat (2) @(posedge clk_i);
        forced_ev <= '0;
        n = 0;
        d = '0;
        while (d[1] !== 1'b1 && n < TIMEOUT) begin
            apb_read(hpm_pkg::ADDR_OVF_STATUS, d, e);
            n++;
        end
        if (d[1] !== 1'b1) abort_run("overflow status bit 1 was never set");
        check_word("prdata_o ovf status", d, 32'h2);
        check_counter(cnt_addr(1), '0);
        repeat (4) begin
            @(negedge clk_i);
            check_word("irq_o", {31'b0, irq_o}, '0);  // still masked
        end
        apb_write(hpm_pkg::ADDR_OVF_ENABLE, 32'h2);
        wait_irq(1'b1);
        apb_write(hpm_pkg::ADDR_OVF_STATUS, 32'h2);  // write one to clear
        wait_irq(1'b0);
        check_read(hpm_pkg::ADDR_OVF_STATUS, '0);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/hpm_pkg.sv
source/hpm_bus_if.sv
source/hpm_fixed_counters.sv
source/hpm_event_counters.sv
source/hpm_apb_access.sv
source/hpm_top.sv
verification/tb_hpm_top.sv
